/* common/io_regs_pkg.sv */
// io register map package with host addresses, register widths and control bit positions
package io_regs_pkg;

	localparam int PIN_COUNT = 7;
	localparam int SCTRL_WIDTH = 5;
	localparam int SCTRL_WR_LSB = 3; // serial control lives in bits 7..3 of the host word

	typedef logic [3:0] reg_addr_t;
	typedef logic [PIN_COUNT-1:0] pin_vec_t;
	typedef logic [7:0] byte_t;

	// native register map, address 0 is unused and reads as zero
	localparam reg_addr_t REG_DATA_A = 4'd1;
	localparam reg_addr_t REG_DATA_B = 4'd2;
	localparam reg_addr_t REG_DATA_C = 4'd3;
	localparam reg_addr_t REG_CTRL_A = 4'd4;
	localparam reg_addr_t REG_CTRL_B = 4'd5;
	localparam reg_addr_t REG_CTRL_C = 4'd6;
	localparam reg_addr_t REG_TXD_A = 4'd7;
	localparam reg_addr_t REG_RXD_A = 4'd8;
	localparam reg_addr_t REG_SCTRL_A = 4'd9;
	localparam reg_addr_t REG_TXD_B = 4'd10;
	localparam reg_addr_t REG_RXD_B = 4'd11;
	localparam reg_addr_t REG_SCTRL_B = 4'd12;
	localparam reg_addr_t REG_TXD_C = 4'd13;
	localparam reg_addr_t REG_RXD_C = 4'd14;
	localparam reg_addr_t REG_SCTRL_C = 4'd15;

	localparam int CTRL_TH_IRQ_BIT = 7; // pin 6 interrupt enable

	// bit positions inside the stored serial control field
	localparam int SCTRL_RX_IRQ_BIT = 0;
	localparam int SCTRL_TX_EN_BIT = 1;
	localparam int SCTRL_RX_EN_BIT = 2;
	localparam int SCTRL_BAUD_LSB = 3;

	localparam int TX_PIN = 4;
	localparam int RX_PIN = 5;
	localparam int TH_PIN = 6;

endpackage

/* common/uart_pkg.sv */
// serial link package with frame format, oversampling and baud rate selection
package uart_pkg;

	localparam int BAUD_RATES = 4;
	typedef logic [1:0] baud_sel_t;

	localparam int OVERSAMPLE = 8; // sample ticks per bit
	localparam int OS_W = $clog2(OVERSAMPLE);

	// 8N1 frame, data goes out lsb first
	localparam int FRAME_DATA_BITS = 8;
	localparam int FRAME_BITS = FRAME_DATA_BITS + 2;
	localparam int BIT_CNT_W = $clog2(FRAME_BITS);

	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT = 1'b1; // also the idle level of the line

	// divisors on top of the base tick, indexed by the baud select
	localparam int STEP_W = 5;
	localparam logic [BAUD_RATES-1:0][STEP_W-1:0] BAUD_STEP = {
		5'd16,
		5'd4,
		5'd2,
		5'd1
	};

endpackage

/* uart/uart_tx.sv */
// serial transmitter sending one 8N1 frame per loaded byte on bit tick enables
module uart_tx import uart_pkg::*;
	(
	input logic MCLK,
	input logic rst_n_i,
	input logic en_i,
	input logic bit_tick_i,
	input logic load_i,
	input logic [FRAME_DATA_BITS-1:0] data_i,
	output logic busy_o,
	output logic line_o
	);

	logic pending; // a byte waits in the holding register
	logic active;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [FRAME_DATA_BITS-1:0] shift_q;
	logic frame_end;
	logic start_frame;

	assign frame_end = active && (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));
	assign start_frame = en_i && bit_tick_i && pending && (!active || frame_end);

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			pending <= 1'b0;
			active <= 1'b0;
			bit_cnt <= '0;
			line_o <= STOP_BIT;
		end
		else
		begin
			if (!en_i)
			begin
				active <= 1'b0;
				line_o <= STOP_BIT;
			end
			else if (start_frame)
			begin
				pending <= 1'b0;
				active <= 1'b1;
				bit_cnt <= '0;
				line_o <= START_BIT;
			end
			else if (bit_tick_i && active)
			begin
				if (frame_end)
				begin
					active <= 1'b0; // stop bit done
					line_o <= STOP_BIT;
				end
				else
				begin
					bit_cnt <= bit_cnt + 1'b1;
					line_o <= (bit_cnt == BIT_CNT_W'(FRAME_DATA_BITS)) ? STOP_BIT : shift_q[0];
				end
			end
			if (load_i)
				pending <= 1'b1; // a write always wins over the pickup
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (start_frame)
			shift_q <= data_i;
		else if (en_i && bit_tick_i && active)
			shift_q <= shift_q >> 1;
	end

	assign busy_o = pending | active;

endmodule

/* uart/uart_rx.sv */
// oversampling serial receiver with ready and framing error flags
module uart_rx import uart_pkg::*;
	(
	input logic MCLK,
	input logic rst_n_i,
	input logic en_i,
	input logic sample_tick_i,
	input logic line_i,
	input logic clear_i,
	output logic [FRAME_DATA_BITS-1:0] data_o,
	output logic ready_o,
	output logic error_o
	);

	localparam logic [OS_W-1:0] MID = OS_W'(OVERSAMPLE / 2 - 1);

	logic line_s;
	logic line_prev;
	logic active;
	logic [OS_W-1:0] os_cnt;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [FRAME_DATA_BITS-1:0] shift_q;
	logic stop_seen;
	logic stop_val;
	logic sample_mid;
	logic last_bit;

	assign sample_mid = en_i && sample_tick_i && active && (os_cnt == MID);
	assign last_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			line_s <= STOP_BIT;
			line_prev <= STOP_BIT;
			active <= 1'b0;
			os_cnt <= '0;
			bit_cnt <= '0;
			stop_seen <= 1'b0;
		end
		else
		begin
			line_s <= line_i;
			stop_seen <= 1'b0;
			if (!en_i)
			begin
				active <= 1'b0;
				line_prev <= STOP_BIT;
			end
			else if (sample_tick_i)
			begin
				line_prev <= line_s;
				if (!active)
				begin
					if (line_prev == STOP_BIT && line_s == START_BIT)
					begin
						active <= 1'b1; // falling edge, start bit begins
						os_cnt <= '0;
						bit_cnt <= '0;
					end
				end
				else
				begin
					os_cnt <= os_cnt + 1'b1;
					if (os_cnt == MID)
					begin
						if (bit_cnt == '0 && line_s != START_BIT)
							active <= 1'b0; // glitch, not a start bit
						else if (last_bit)
						begin
							active <= 1'b0;
							stop_seen <= 1'b1;
						end
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (sample_mid && bit_cnt != '0 && !last_bit)
			shift_q <= {line_s, shift_q[FRAME_DATA_BITS-1:1]}; // lsb arrives first
		if (sample_mid && last_bit)
			stop_val <= line_s;
	end

	// a new frame takes priority over a read in the same cycle
	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			data_o <= '0;
			ready_o <= 1'b0;
			error_o <= 1'b0;
		end
		else if (stop_seen)
		begin
			data_o <= shift_q;
			ready_o <= 1'b1;
			error_o <= (stop_val != STOP_BIT);
		end
		else if (clear_i)
		begin
			ready_o <= 1'b0;
			error_o <= 1'b0;
		end
	end

endmodule

/* src/baud_gen.sv */
// baud generator producing sample and bit clock enables for the four serial rates
module baud_gen import uart_pkg::*;
	#(
	parameter int BAUD_BASE_DIV = 4
	)
	(
	input logic MCLK,
	input logic rst_n_i,
	output logic [BAUD_RATES-1:0] sample_tick_o,
	output logic [BAUD_RATES-1:0] bit_tick_o
	);

	localparam int BASE_W = (BAUD_BASE_DIV > 1) ? $clog2(BAUD_BASE_DIV) : 1;
	localparam int PRE_W = $clog2(BAUD_STEP[BAUD_RATES-1]);

	logic [BASE_W-1:0] base_cnt;
	logic [PRE_W-1:0] pre_cnt;
	logic base_tick;

	assign base_tick = (base_cnt == BASE_W'(BAUD_BASE_DIV - 1));

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			base_cnt <= '0;
			pre_cnt <= '0;
		end
		else if (base_tick)
		begin
			base_cnt <= '0;
			pre_cnt <= pre_cnt + 1'b1; // wraps at the slowest step
		end
		else
			base_cnt <= base_cnt + 1'b1;
	end

	for (genvar r = 0; r < BAUD_RATES; r++)
	begin : g_rate
		logic [OS_W-1:0] os_cnt;

		// steps are powers of two so a mask on the prescaler picks the rate
		assign sample_tick_o[r] = base_tick
			&& ((pre_cnt & PRE_W'(BAUD_STEP[r] - 1)) == PRE_W'(BAUD_STEP[r] - 1));
		assign bit_tick_o[r] = sample_tick_o[r] && (os_cnt == OS_W'(OVERSAMPLE - 1));

		always_ff @(posedge MCLK)
		begin
			if (!rst_n_i)
				os_cnt <= '0;
			else if (sample_tick_o[r])
				os_cnt <= os_cnt + 1'b1;
		end
	end

endmodule

/* src/host_decode.sv */
// host register decoder turning bus strobes into per-port write and read pulses
module host_decode import io_regs_pkg::*;
	(
	input logic MCLK,
	input logic rst_n_i,
	input reg_addr_t addr_i,
	input byte_t wdata_i,
	input logic wr_i,
	input logic rd_i,
	output byte_t rdata_o,
	output logic [2:0] data_wr_o, // bit 0 is port A
	output logic [2:0] ctrl_wr_o,
	output logic [2:0] txd_wr_o,
	output logic [2:0] sctrl_wr_o,
	output logic [2:0] rxd_rd_o,
	output byte_t wdata_o,
	input byte_t data_rd_a_i, data_rd_b_i, data_rd_c_i,
	input byte_t ctrl_q_a_i, ctrl_q_b_i, ctrl_q_c_i,
	input byte_t txd_q_a_i, txd_q_b_i, txd_q_c_i,
	input byte_t rxd_q_a_i, rxd_q_b_i, rxd_q_c_i,
	input byte_t status_a_i, status_b_i, status_c_i
	);

	byte_t rd_mux;

	assign wdata_o = wdata_i;

	always_comb
	begin
		data_wr_o = '0;
		ctrl_wr_o = '0;
		txd_wr_o = '0;
		sctrl_wr_o = '0;
		if (wr_i)
		begin
			case (addr_i)
				REG_DATA_A: data_wr_o[0] = 1'b1;
				REG_DATA_B: data_wr_o[1] = 1'b1;
				REG_DATA_C: data_wr_o[2] = 1'b1;
				REG_CTRL_A: ctrl_wr_o[0] = 1'b1;
				REG_CTRL_B: ctrl_wr_o[1] = 1'b1;
				REG_CTRL_C: ctrl_wr_o[2] = 1'b1;
				REG_TXD_A: txd_wr_o[0] = 1'b1;
				REG_TXD_B: txd_wr_o[1] = 1'b1;
				REG_TXD_C: txd_wr_o[2] = 1'b1;
				REG_SCTRL_A: sctrl_wr_o[0] = 1'b1;
				REG_SCTRL_B: sctrl_wr_o[1] = 1'b1;
				REG_SCTRL_C: sctrl_wr_o[2] = 1'b1;
				default: ; // rxd and address 0 are read only
			endcase
		end
	end

	// reading rxd acknowledges the received byte in that port
	always_comb
	begin
		rxd_rd_o = '0;
		if (rd_i)
		begin
			rxd_rd_o[0] = (addr_i == REG_RXD_A);
			rxd_rd_o[1] = (addr_i == REG_RXD_B);
			rxd_rd_o[2] = (addr_i == REG_RXD_C);
		end
	end

	always_comb
	begin
		case (addr_i)
			REG_DATA_A: rd_mux = data_rd_a_i;
			REG_DATA_B: rd_mux = data_rd_b_i;
			REG_DATA_C: rd_mux = data_rd_c_i;
			REG_CTRL_A: rd_mux = ctrl_q_a_i;
			REG_CTRL_B: rd_mux = ctrl_q_b_i;
			REG_CTRL_C: rd_mux = ctrl_q_c_i;
			REG_TXD_A: rd_mux = txd_q_a_i;
			REG_RXD_A: rd_mux = rxd_q_a_i;
			REG_SCTRL_A: rd_mux = status_a_i;
			REG_TXD_B: rd_mux = txd_q_b_i;
			REG_RXD_B: rd_mux = rxd_q_b_i;
			REG_SCTRL_B: rd_mux = status_b_i;
			REG_TXD_C: rd_mux = txd_q_c_i;
			REG_RXD_C: rd_mux = rxd_q_c_i;
			REG_SCTRL_C: rd_mux = status_c_i;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
			rdata_o <= '0;
		else if (rd_i)
			rdata_o <= rd_mux; // held until the next read
	end

endmodule

/* src/ctrl_port.sv */
// controller port with pin registers, serial control, transmit buffer and interrupt sources
module ctrl_port import io_regs_pkg::*, uart_pkg::*;
	(
	input logic MCLK,
	input logic rst_n_i,
	input pin_vec_t pins_i,
	output pin_vec_t pins_o,
	output pin_vec_t dir_o,
	input byte_t wdata_i,
	input logic data_wr_i,
	input logic ctrl_wr_i,
	input logic txd_wr_i,
	input logic sctrl_wr_i,
	input logic rxd_rd_i,
	input logic [BAUD_RATES-1:0] sample_tick_i,
	input logic [BAUD_RATES-1:0] bit_tick_i,
	output byte_t data_rd_o,
	output byte_t ctrl_q_o,
	output byte_t txd_q_o,
	output byte_t rxd_q_o,
	output byte_t status_o,
	output logic irq_o
	);

	byte_t data_q;
	byte_t ctrl_q;
	byte_t txd_q; // holding register, the transmitter picks it up on its next bit tick
	logic [SCTRL_WIDTH-1:0] sctrl_q;
	baud_sel_t baud_sel;
	logic tx_en, rx_en;
	logic tx_busy, tx_line;
	logic rx_ready, rx_error;

	always_ff @(posedge MCLK)
	begin
		if (!rst_n_i)
		begin
			data_q <= '0;
			ctrl_q <= '0;
			txd_q <= '0;
			sctrl_q <= '0;
		end
		else
		begin
			if (data_wr_i)
				data_q <= wdata_i;
			if (ctrl_wr_i)
				ctrl_q <= wdata_i;
			if (txd_wr_i)
				txd_q <= wdata_i;
			if (sctrl_wr_i)
				sctrl_q <= wdata_i[SCTRL_WR_LSB +: SCTRL_WIDTH];
		end
	end

	assign baud_sel = sctrl_q[SCTRL_BAUD_LSB +: $bits(baud_sel_t)];
	assign tx_en = sctrl_q[SCTRL_TX_EN_BIT];
	assign rx_en = sctrl_q[SCTRL_RX_EN_BIT];

	// serial functions take over pins 4 and 5
	always_comb
	begin
		pins_o = data_q[PIN_COUNT-1:0];
		dir_o = ctrl_q[PIN_COUNT-1:0];
		if (tx_en)
		begin
			pins_o[TX_PIN] = tx_line;
			dir_o[TX_PIN] = 1'b1;
		end
		if (rx_en)
			dir_o[RX_PIN] = 1'b0;
	end

	uart_tx u_tx (.MCLK(MCLK), .rst_n_i(rst_n_i), .en_i(tx_en), .bit_tick_i(bit_tick_i[baud_sel]),
		.load_i(txd_wr_i), .data_i(txd_q), .busy_o(tx_busy), .line_o(tx_line));

	uart_rx u_rx (.MCLK(MCLK), .rst_n_i(rst_n_i), .en_i(rx_en),
		.sample_tick_i(sample_tick_i[baud_sel]), .line_i(pins_i[RX_PIN]), .clear_i(rxd_rd_i),
		.data_o(rxd_q_o), .ready_o(rx_ready), .error_o(rx_error));

	assign data_rd_o = {data_q[7], pins_i}; // stored bit 7 above the live pins
	assign ctrl_q_o = ctrl_q;
	assign txd_q_o = txd_q;
	assign status_o = {sctrl_q, rx_error, rx_ready, tx_busy};

	assign irq_o = (ctrl_q[CTRL_TH_IRQ_BIT] & ~pins_i[TH_PIN])
		| (rx_ready & sctrl_q[SCTRL_RX_IRQ_BIT]);

endmodule

/* src/md_io_top.sv */
// io chip top level joining the host register decoder, the baud generator and three controller ports
module md_io_top import io_regs_pkg::*, uart_pkg::*;
	#(
	parameter int BAUD_BASE_DIV = 4
	)
	(
	input logic MCLK,
	input logic rst_n_i,
	input reg_addr_t addr_i,
	input byte_t wdata_i,
	input logic wr_i,
	input logic rd_i,
	output byte_t rdata_o,
	input pin_vec_t port_a_i,
	input pin_vec_t port_b_i,
	input pin_vec_t port_c_i,
	output pin_vec_t port_a_o,
	output pin_vec_t port_b_o,
	output pin_vec_t port_c_o,
	output pin_vec_t port_a_dir_o,
	output pin_vec_t port_b_dir_o,
	output pin_vec_t port_c_dir_o,
	output logic irq_n_o
	);

	logic [2:0] data_wr;
	logic [2:0] ctrl_wr;
	logic [2:0] txd_wr;
	logic [2:0] sctrl_wr;
	logic [2:0] rxd_rd;
	byte_t wdata;
	logic [BAUD_RATES-1:0] sample_tick;
	logic [BAUD_RATES-1:0] bit_tick;

	byte_t data_rd_a, ctrl_q_a, txd_q_a, rxd_q_a, status_a;
	byte_t data_rd_b, ctrl_q_b, txd_q_b, rxd_q_b, status_b;
	byte_t data_rd_c, ctrl_q_c, txd_q_c, rxd_q_c, status_c;
	logic irq_a, irq_b, irq_c;

	host_decode u_decode (.MCLK(MCLK), .rst_n_i(rst_n_i), .addr_i(addr_i), .wdata_i(wdata_i),
		.wr_i(wr_i), .rd_i(rd_i), .rdata_o(rdata_o), .data_wr_o(data_wr), .ctrl_wr_o(ctrl_wr),
		.txd_wr_o(txd_wr), .sctrl_wr_o(sctrl_wr), .rxd_rd_o(rxd_rd), .wdata_o(wdata),
		.data_rd_a_i(data_rd_a), .data_rd_b_i(data_rd_b), .data_rd_c_i(data_rd_c),
		.ctrl_q_a_i(ctrl_q_a), .ctrl_q_b_i(ctrl_q_b), .ctrl_q_c_i(ctrl_q_c),
		.txd_q_a_i(txd_q_a), .txd_q_b_i(txd_q_b), .txd_q_c_i(txd_q_c),
		.rxd_q_a_i(rxd_q_a), .rxd_q_b_i(rxd_q_b), .rxd_q_c_i(rxd_q_c),
		.status_a_i(status_a), .status_b_i(status_b), .status_c_i(status_c));

	baud_gen #(.BAUD_BASE_DIV(BAUD_BASE_DIV)) u_baud (.MCLK(MCLK), .rst_n_i(rst_n_i),
		.sample_tick_o(sample_tick), .bit_tick_o(bit_tick));

	ctrl_port u_port_a (.MCLK(MCLK), .rst_n_i(rst_n_i), .pins_i(port_a_i), .pins_o(port_a_o),
		.dir_o(port_a_dir_o), .wdata_i(wdata), .data_wr_i(data_wr[0]), .ctrl_wr_i(ctrl_wr[0]),
		.txd_wr_i(txd_wr[0]), .sctrl_wr_i(sctrl_wr[0]), .rxd_rd_i(rxd_rd[0]),
		.sample_tick_i(sample_tick), .bit_tick_i(bit_tick), .data_rd_o(data_rd_a),
		.ctrl_q_o(ctrl_q_a), .txd_q_o(txd_q_a), .rxd_q_o(rxd_q_a), .status_o(status_a),
		.irq_o(irq_a));

	ctrl_port u_port_b (.MCLK(MCLK), .rst_n_i(rst_n_i), .pins_i(port_b_i), .pins_o(port_b_o),
		.dir_o(port_b_dir_o), .wdata_i(wdata), .data_wr_i(data_wr[1]), .ctrl_wr_i(ctrl_wr[1]),
		.txd_wr_i(txd_wr[1]), .sctrl_wr_i(sctrl_wr[1]), .rxd_rd_i(rxd_rd[1]),
		.sample_tick_i(sample_tick), .bit_tick_i(bit_tick), .data_rd_o(data_rd_b),
		.ctrl_q_o(ctrl_q_b), .txd_q_o(txd_q_b), .rxd_q_o(rxd_q_b), .status_o(status_b),
		.irq_o(irq_b));

	ctrl_port u_port_c (.MCLK(MCLK), .rst_n_i(rst_n_i), .pins_i(port_c_i), .pins_o(port_c_o),
		.dir_o(port_c_dir_o), .wdata_i(wdata), .data_wr_i(data_wr[2]), .ctrl_wr_i(ctrl_wr[2]),
		.txd_wr_i(txd_wr[2]), .sctrl_wr_i(sctrl_wr[2]), .rxd_rd_i(rxd_rd[2]),
		.sample_tick_i(sample_tick), .bit_tick_i(bit_tick), .data_rd_o(data_rd_c),
		.ctrl_q_o(ctrl_q_c), .txd_q_o(txd_q_c), .rxd_q_o(rxd_q_c), .status_o(status_c),
		.irq_o(irq_c));

	assign irq_n_o = ~(irq_a | irq_b | irq_c); // one shared open-drain style line

endmodule

/* testbench/md_io_sva.sv */
// bound checks on the io chip top for the interrupt rule and serial pin ownership
module md_io_sva import io_regs_pkg::*;
	(
	input logic MCLK,
	input logic rst_n_i,
	input logic irq_a_i,
	input logic irq_b_i,
	input logic irq_c_i,
	input pin_vec_t pins_a_i,
	input pin_vec_t pins_b_i,
	input pin_vec_t pins_c_i,
	input pin_vec_t pins_out_a_i,
	input pin_vec_t dir_a_i,
	input pin_vec_t dir_b_i,
	input byte_t ctrl_a_i,
	input byte_t ctrl_b_i,
	input byte_t ctrl_c_i,
	input byte_t status_a_i,
	input byte_t status_b_i,
	input byte_t status_c_i
	);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ST_BUSY = 0;
	localparam int ST_READY = 1;
	localparam int ST_SCTRL = 3; // serial control field sits above busy, ready and error

	a_irq_a: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		irq_a_i == ((ctrl_a_i[CTRL_TH_IRQ_BIT] && !pins_a_i[TH_PIN])
			|| (status_a_i[ST_READY] && status_a_i[ST_SCTRL + SCTRL_RX_IRQ_BIT])))
		else $error("port A interrupt does not follow its enables");

	a_irq_b: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		irq_b_i == ((ctrl_b_i[CTRL_TH_IRQ_BIT] && !pins_b_i[TH_PIN])
			|| (status_b_i[ST_READY] && status_b_i[ST_SCTRL + SCTRL_RX_IRQ_BIT])))
		else $error("port B interrupt does not follow its enables");

	a_irq_c: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		irq_c_i == ((ctrl_c_i[CTRL_TH_IRQ_BIT] && !pins_c_i[TH_PIN])
			|| (status_c_i[ST_READY] && status_c_i[ST_SCTRL + SCTRL_RX_IRQ_BIT])))
		else $error("port C interrupt does not follow its enables");

	// an idle transmitter keeps the line at the stop level
	a_tx_idle: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		(status_a_i[ST_SCTRL + SCTRL_TX_EN_BIT] && !status_a_i[ST_BUSY]) |-> pins_out_a_i[TX_PIN])
		else $error("port A transmit line is low while the transmitter is idle");

	a_tx_dir: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		status_a_i[ST_SCTRL + SCTRL_TX_EN_BIT] |-> dir_a_i[TX_PIN])
		else $error("port A transmit pin is not an output while serial out is on");

	a_rx_dir: assert property (@(posedge MCLK) disable iff (!rst_n_i)
		status_b_i[ST_SCTRL + SCTRL_RX_EN_BIT] |-> !dir_b_i[RX_PIN])
		else $error("port B receive pin is not an input while serial in is on");

endmodule

bind md_io_top md_io_sva u_sva (.MCLK(MCLK), .rst_n_i(rst_n_i),
	.irq_a_i(irq_a), .irq_b_i(irq_b), .irq_c_i(irq_c),
	.pins_a_i(port_a_i), .pins_b_i(port_b_i), .pins_c_i(port_c_i),
	.pins_out_a_i(port_a_o), .dir_a_i(port_a_dir_o), .dir_b_i(port_b_dir_o),
	.ctrl_a_i(ctrl_q_a), .ctrl_b_i(ctrl_q_b), .ctrl_c_i(ctrl_q_c),
	.status_a_i(status_a), .status_b_i(status_b), .status_c_i(status_c));

/* testbench/md_io_tb.sv */
// testbench for the io chip with host register traffic and a port A to port B serial loopback
module md_io_tb import io_regs_pkg::*, uart_pkg::*;
	;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int BASE_DIV = 4;
	localparam int TIMEOUT_CYCLES = 20000; // well above the frames and register traffic of the run

	logic MCLK;
	logic rst_n;
	reg_addr_t addr;
	byte_t wdata, rdata;
	logic wr, rd;
	logic irq_n;
	logic rx_force_low; // pulls port B receive pin low for the framing error frame
	pin_vec_t pins_drv [3];
	pin_vec_t port_a_i, port_b_i, port_c_i;
	pin_vec_t port_a_o, port_b_o, port_c_o;
	pin_vec_t port_a_dir, port_b_dir, port_c_dir;
	byte_t data_model [3];
	byte_t ctrl_model [3];
	logic [31:0] lcg_state = 32'd95;
	int cycle_cnt = 0;

	assign port_a_i = pins_drv[0];
	assign port_c_i = pins_drv[2];

	always_comb
	begin
		port_b_i = pins_drv[1];
		port_b_i[RX_PIN] = rx_force_low ? 1'b0 : port_a_o[TX_PIN]; // loopback from A
	end

	md_io_top #(.BAUD_BASE_DIV(BASE_DIV)) u_dut (.MCLK(MCLK), .rst_n_i(rst_n), .addr_i(addr),
		.wdata_i(wdata), .wr_i(wr), .rd_i(rd), .rdata_o(rdata), .port_a_i(port_a_i),
		.port_b_i(port_b_i), .port_c_i(port_c_i), .port_a_o(port_a_o), .port_b_o(port_b_o),
		.port_c_o(port_c_o), .port_a_dir_o(port_a_dir), .port_b_dir_o(port_b_dir),
		.port_c_dir_o(port_c_dir), .irq_n_o(irq_n));

	initial
	begin
		MCLK = 1'b0;
		forever #50 MCLK = ~MCLK;
	end

	always @(posedge MCLK)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles while waiting for the DUT", cycle_cnt);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	function automatic byte_t next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// the three ports sit at a fixed stride in the map
	function automatic reg_addr_t port_addr(input reg_addr_t base, input int port, input int stride);
		return reg_addr_t'(int'(base) + stride * port);
	endfunction

	function automatic byte_t sctrl_word(input logic tx_en, input logic rx_en, input logic rx_irq,
		input baud_sel_t baud);
		byte_t w;
		w = '0;
		w[SCTRL_WR_LSB + SCTRL_TX_EN_BIT] = tx_en;
		w[SCTRL_WR_LSB + SCTRL_RX_EN_BIT] = rx_en;
		w[SCTRL_WR_LSB + SCTRL_RX_IRQ_BIT] = rx_irq;
		w[SCTRL_WR_LSB + SCTRL_BAUD_LSB +: 2] = baud;
		return w;
	endfunction

	function automatic logic irq_n_expected(input logic ready_b, input logic rx_irq_b);
		logic any;
		any = ready_b && rx_irq_b;
		for (int p = 0; p < 3; p++)
			if (ctrl_model[p][CTRL_TH_IRQ_BIT] && !pins_drv[p][TH_PIN])
				any = 1'b1;
		return !any;
	endfunction

	task automatic check_equal(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic host_write(input reg_addr_t a, input byte_t d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		@(negedge MCLK);
		wr = 1'b0;
	endtask

	task automatic host_read(input reg_addr_t a, output byte_t d);
		addr = a;
		rd = 1'b1;
		@(negedge MCLK);
		rd = 1'b0;
		d = rdata; // registered at the rising edge in between
	endtask

	task automatic read_expect(input string name, input reg_addr_t a, input byte_t expected);
		byte_t d;
		host_read(a, d);
		check_equal(name, expected, d);
	endtask

	// polls a serial status register until one flag reaches the wanted level
	task automatic wait_flag(input int port, input int bit_pos, input logic level, output byte_t st);
		do
			host_read(port_addr(REG_SCTRL_A, port, 3), st);
		while (st[bit_pos] != level);
	endtask

	task automatic send_loopback(input byte_t b, input byte_t sctrl_a, input byte_t sctrl_b);
		byte_t st;
		host_write(REG_TXD_A, b);
		read_expect("txd readback", REG_TXD_A, b);
		wait_flag(1, 1, 1'b1, st);
		check_equal("rx status after frame", sctrl_b | 8'h02, st);
		wait_flag(0, 0, 1'b0, st);
		check_equal("tx status after frame", sctrl_a, st);
		read_expect("rx data", REG_RXD_B, b);
		read_expect("rx status after read", REG_SCTRL_B, sctrl_b);
	endtask

	initial
	begin
		byte_t d, c, st, b, sctrl_a, sctrl_b;
		pin_vec_t exp_pins, exp_dir;
		baud_sel_t baud;
		rst_n = 1'b0;
		addr = '0;
		wdata = '0;
		wr = 1'b0;
		rd = 1'b0;
		rx_force_low = 1'b0;
		for (int p = 0; p < 3; p++)
		begin
			pins_drv[p] = 7'h7f;
			data_model[p] = '0;
			ctrl_model[p] = '0;
		end
		repeat (2) @(posedge MCLK);
		@(negedge MCLK);
		rst_n = 1'b1;

		check_equal("reset dir", 0, {port_a_dir, port_b_dir, port_c_dir});
		check_equal("reset irq_n", 1, irq_n);
		for (int p = 0; p < 3; p++)
		begin
			read_expect($sformatf("reset ctrl %0d", p), port_addr(REG_CTRL_A, p, 1), 8'h00);
			read_expect($sformatf("reset sctrl %0d", p), port_addr(REG_SCTRL_A, p, 3), 8'h00);
			read_expect($sformatf("reset rxd %0d", p), port_addr(REG_RXD_A, p, 3), 8'h00);
		end

		// pin 6 stays high and its enable off so no interrupt fires yet
		for (int p = 0; p < 3; p++)
		begin
			d = next_rand();
			c = next_rand() & 8'h7f;
			pins_drv[p] = pin_vec_t'(next_rand()) | pin_vec_t'(1 << TH_PIN);
			data_model[p] = d;
			ctrl_model[p] = c;
			host_write(port_addr(REG_DATA_A, p, 1), d);
			host_write(port_addr(REG_CTRL_A, p, 1), c);
			check_equal("pin out", d[6:0], (p == 0) ? port_a_o : (p == 1) ? port_b_o : port_c_o);
			check_equal("pin dir", c[6:0],
				(p == 0) ? port_a_dir : (p == 1) ? port_b_dir : port_c_dir);
			exp_pins = pins_drv[p];
			if (p == 1)
				exp_pins[RX_PIN] = data_model[0][TX_PIN];
			read_expect($sformatf("data read %0d", p), port_addr(REG_DATA_A, p, 1),
				{d[7], exp_pins});
			read_expect($sformatf("ctrl read %0d", p), port_addr(REG_CTRL_A, p, 1), c);
		end
		check_equal("irq_n after pin writes", 1, irq_n);

		for (int i = 0; i < 2; i++)
		begin
			baud = (i == 0) ? 2'd0 : 2'd2;
			sctrl_a = sctrl_word(1'b1, 1'b0, 1'b0, baud);
			sctrl_b = sctrl_word(1'b0, 1'b1, 1'b0, baud);
			host_write(REG_SCTRL_A, sctrl_a);
			host_write(REG_SCTRL_B, sctrl_b);
			exp_dir = ctrl_model[0][6:0] | pin_vec_t'(1 << TX_PIN);
			check_equal("serial dir A", exp_dir, port_a_dir);
			exp_dir = ctrl_model[1][6:0] & ~pin_vec_t'(1 << RX_PIN);
			check_equal("serial dir B", exp_dir, port_b_dir);
			check_equal("tx idle line", 1, port_a_o[TX_PIN]);
			for (int k = 0; k < 2; k++)
				send_loopback(next_rand(), sctrl_a, sctrl_b);
		end

		// a frame held low through its stop bit is a framing error
		sctrl_a = sctrl_word(1'b1, 1'b0, 1'b0, 2'd0);
		sctrl_b = sctrl_word(1'b0, 1'b1, 1'b0, 2'd0);
		host_write(REG_SCTRL_A, sctrl_a);
		host_write(REG_SCTRL_B, sctrl_b);
		rx_force_low = 1'b1;
		wait_flag(1, 1, 1'b1, st);
		check_equal("framing error status", sctrl_b | 8'h06, st);
		rx_force_low = 1'b0;
		read_expect("framing error data", REG_RXD_B, 8'h00);
		read_expect("flags after rxd read", REG_SCTRL_B, sctrl_b);

		ctrl_model[2] = ctrl_model[2] | 8'h80;
		host_write(REG_CTRL_C, ctrl_model[2]);
		check_equal("irq_n pin 6 high", irq_n_expected(1'b0, 1'b0), irq_n);
		pins_drv[2][TH_PIN] = 1'b0;
		@(negedge MCLK);
		check_equal("irq_n pin 6 low", irq_n_expected(1'b0, 1'b0), irq_n);
		ctrl_model[2] = ctrl_model[2] & 8'h7f;
		host_write(REG_CTRL_C, ctrl_model[2]);
		check_equal("irq_n pin 6 masked", irq_n_expected(1'b0, 1'b0), irq_n);
		pins_drv[2][TH_PIN] = 1'b1;

		sctrl_b = sctrl_word(1'b0, 1'b1, 1'b1, 2'd0);
		host_write(REG_SCTRL_B, sctrl_b);
		b = next_rand();
		host_write(REG_TXD_A, b);
		wait_flag(1, 1, 1'b1, st);
		check_equal("irq_n rx ready", irq_n_expected(1'b1, 1'b1), irq_n);
		read_expect("irq rx data", REG_RXD_B, b);
		check_equal("irq_n after rxd read", irq_n_expected(1'b0, 1'b1), irq_n);

		$display("All tests passed");
		$finish;
	end

endmodule

/* md_io.f */
common/io_regs_pkg.sv
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
src/baud_gen.sv
src/host_decode.sv
src/ctrl_port.sv
src/md_io_top.sv
testbench/md_io_sva.sv
testbench/md_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module md_io_tb -f md_io.f -o md_io_sim
./obj_dir/md_io_sim | tee sim.log
if grep -q "All tests passed" sim.log
then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
